//--- verilog/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // data RAM geometry, word addressed
    localparam int RAM_AW    = 8;
    localparam int RAM_WORDS = 2 ** RAM_AW;

    typedef enum logic [3:0] {
        LS_NONE = 4'd0,
        LS_LB   = 4'd1,
        LS_LBU  = 4'd2,
        LS_LH   = 4'd3,
        LS_LHU  = 4'd4,
        LS_LW   = 4'd5,
        LS_LWL  = 4'd6,
        LS_LWR  = 4'd7,
        LS_SB   = 4'd8,
        LS_SH   = 4'd9,
        LS_SW   = 4'd10,
        LS_SWL  = 4'd11,
        LS_SWR  = 4'd12
    } ls_sel_e;

    // request from the execute stage
    typedef struct packed {
        logic        ls_ena;
        ls_sel_e     ls_sel;
        logic [31:0] ls_addr;
        logic [31:0] rt_data;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        logic        ex_exc;
    } mem_req_t;

    // single port of the data RAM
    typedef struct packed {
        logic              en;
        logic [3:0]        wen;
        logic [RAM_AW-1:0] word_addr;
        logic [31:0]       wdata;
    } ram_req_t;

    // what survives into the cycle after the RAM read
    typedef struct packed {
        logic        valid;
        logic        ls_ena;
        ls_sel_e     ls_sel;
        logic [1:0]  addr_lo;
        logic [31:0] rt_data;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        logic        exc;
    } mem_stage_t;

    // write-back record
    typedef struct packed {
        logic        valid;
        logic        w_reg_ena;
        logic [4:0]  w_reg_dst;
        logic [31:0] r_data;
        logic        has_exception;
    } wb_t;

endpackage

`default_nettype wire

//--- verilog/store_format.sv
`default_nettype none

module store_format (
    input  lsu_pkg::mem_req_t req,
    input  logic              mem_exc,
    output lsu_pkg::ram_req_t ram_req,
    output logic              adel,
    output logic              ades
);
    import lsu_pkg::*;

    logic [1:0]  addr_lo;
    logic [3:0]  wen_raw;
    logic [31:0] wdata_fmt;
    logic        access_ok;

    assign addr_lo = req.ls_addr[1:0];

    // halfwords need bit 0 clear, words need both low bits clear
    always_comb begin
        adel = 1'b0;
        ades = 1'b0;
        if (req.ls_ena) begin
            case (req.ls_sel)
                LS_LH, LS_LHU: adel = addr_lo[0];
                LS_LW:         adel = |addr_lo;
                LS_SH:         ades = addr_lo[0];
                LS_SW:         ades = |addr_lo;
                default: ;
            endcase
        end
    end

    // byte enables and lane placement of the store data
    always_comb begin
        wen_raw   = 4'b0000;
        wdata_fmt = 32'h0;
        case (req.ls_sel)
            LS_SB: begin
                wen_raw   = 4'b0001 << addr_lo;
                wdata_fmt = {4{req.rt_data[7:0]}};
            end
            LS_SH: begin
                wen_raw   = addr_lo[1] ? 4'b1100 : 4'b0011;
                wdata_fmt = {2{req.rt_data[15:0]}};
            end
            LS_SW: begin
                wen_raw   = 4'b1111;
                wdata_fmt = req.rt_data;
            end
            // upper bytes of rt go to the low lanes, up to the addressed byte
            LS_SWL: begin
                wen_raw   = 4'b1111 >> (~addr_lo);
                wdata_fmt = req.rt_data >> {~addr_lo, 3'b000};
            end
            // low bytes of rt go from the addressed byte upward
            LS_SWR: begin
                wen_raw   = 4'b1111 << addr_lo;
                wdata_fmt = req.rt_data << {addr_lo, 3'b000};
            end
            default: ;
        endcase
    end

    // kill the access on our own error, an upstream exception,
    // or an exception in the instruction already in mem
    assign access_ok = req.ls_ena & ~adel & ~ades & ~req.ex_exc & ~mem_exc;

    always_comb begin
        ram_req.en        = access_ok;
        ram_req.wen       = access_ok ? wen_raw : 4'b0000;
        ram_req.word_addr = req.ls_addr[RAM_AW+1:2];
        ram_req.wdata     = wdata_fmt;
    end

    // an enabled request from execute always carries a real load/store opcode
    always_comb begin
        if (req.ls_ena) begin
            assert (req.ls_sel != LS_NONE && req.ls_sel <= LS_SWR)
                else $error("store_format: enabled request without a load/store opcode");
        end
    end

endmodule

`default_nettype wire

//--- verilog/data_ram.sv
`default_nettype none

module data_ram (
    input  logic              clk,
    input  logic              reset,
    input  lsu_pkg::ram_req_t ram_req,
    output logic [31:0]       rdata
);
    import lsu_pkg::*;

    logic [31:0] mem [RAM_WORDS];

    // per-byte write
    always_ff @(posedge clk) begin
        if (ram_req.en) begin
            for (int i = 0; i < 4; i++) begin
                if (ram_req.wen[i]) begin
                    mem[ram_req.word_addr][8*i +: 8] <= ram_req.wdata[8*i +: 8];
                end
            end
        end
    end

    // read register holds its value while the port is idle
    always_ff @(posedge clk) begin
        if (reset) begin
            rdata <= 32'h0;
        end else if (ram_req.en) begin
            rdata <= mem[ram_req.word_addr];
        end
    end

    // the producer must never raise byte enables on an idle port
    assert property (@(posedge clk) disable iff (reset)
        !ram_req.en |-> (ram_req.wen == 4'b0000))
        else $error("data_ram: write enables set while en is low");

endmodule

`default_nettype wire

//--- verilog/ex_mem_reg.sv
`default_nettype none

module ex_mem_reg (
    input  logic                clk,
    input  logic                reset,
    input  lsu_pkg::mem_req_t   req,
    input  logic                adel,
    input  logic                ades,
    output lsu_pkg::mem_stage_t stage
);

    logic req_valid;
    logic req_exc;

    // anything that loads or writes a register occupies the slot
    assign req_valid = req.ls_ena | req.w_reg_ena;
    assign req_exc   = req.ex_exc | adel | ades;

    always_ff @(posedge clk) begin
        // payload follows the request every cycle
        stage.ls_sel    <= req.ls_sel;
        stage.addr_lo   <= req.ls_addr[1:0];
        stage.rt_data   <= req.rt_data;
        stage.w_reg_dst <= req.w_reg_dst;

        if (reset) begin
            stage.valid     <= 1'b0;
            stage.ls_ena    <= 1'b0;
            stage.w_reg_ena <= 1'b0;
            stage.exc       <= 1'b0;
        end else begin
            stage.valid     <= req_valid;
            stage.ls_ena    <= req.ls_ena;
            stage.w_reg_ena <= req.w_reg_ena;
            stage.exc       <= req_exc;
        end
    end

endmodule

`default_nettype wire

//--- verilog/load_align.sv
`default_nettype none

module load_align (
    input  lsu_pkg::mem_stage_t stage,
    input  logic [31:0]         rdata,
    output lsu_pkg::wb_t        wb
);
    import lsu_pkg::*;

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    logic [31:0] r_data;

    assign byte_lane = rdata[{stage.addr_lo, 3'b000} +: 8];
    assign half_lane = stage.addr_lo[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        r_data = 32'h0;
        if (stage.ls_ena) begin
            case (stage.ls_sel)
                LS_LB:  r_data = {{24{byte_lane[7]}}, byte_lane};
                LS_LBU: r_data = {24'h0, byte_lane};
                LS_LH:  r_data = {{16{half_lane[15]}}, half_lane};
                LS_LHU: r_data = {16'h0, half_lane};
                LS_LW:  r_data = rdata;
                // low RAM lanes fill the top of rt
                LS_LWL: begin
                    case (stage.addr_lo)
                        2'b00:   r_data = {rdata[7:0], stage.rt_data[23:0]};
                        2'b01:   r_data = {rdata[15:0], stage.rt_data[15:0]};
                        2'b10:   r_data = {rdata[23:0], stage.rt_data[7:0]};
                        default: r_data = rdata;
                    endcase
                end
                // high RAM lanes fill the bottom of rt
                LS_LWR: begin
                    case (stage.addr_lo)
                        2'b00:   r_data = rdata;
                        2'b01:   r_data = {stage.rt_data[31:24], rdata[31:8]};
                        2'b10:   r_data = {stage.rt_data[31:16], rdata[31:16]};
                        default: r_data = {stage.rt_data[31:8], rdata[31:24]};
                    endcase
                end
                // stores and idle slots return nothing
                default: r_data = 32'h0;
            endcase
        end
    end

    always_comb begin
        wb.valid         = stage.valid;
        wb.w_reg_ena     = stage.w_reg_ena & ~stage.exc;
        wb.w_reg_dst     = stage.w_reg_dst;
        wb.r_data        = r_data;
        wb.has_exception = stage.exc;
    end

endmodule

`default_nettype wire

//--- verilog/mem_stage.sv
`default_nettype none

module mem_stage (
    input  logic              clk,
    input  logic              reset,
    input  lsu_pkg::mem_req_t req,
    output lsu_pkg::wb_t      wb,
    output logic              adel,
    output logic              ades
);
    import lsu_pkg::*;

    ram_req_t    ram_req;
    mem_stage_t  stage;
    logic [31:0] rdata;

    // request side, same cycle as the execute stage
    store_format u_store_format (
        .req     (req),
        .mem_exc (stage.exc),
        .ram_req (ram_req),
        .adel    (adel),
        .ades    (ades)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .reset   (reset),
        .ram_req (ram_req),
        .rdata   (rdata)
    );

    ex_mem_reg u_ex_mem_reg (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .adel  (adel),
        .ades  (ades),
        .stage (stage)
    );

    // result side, one cycle later
    load_align u_load_align (
        .stage (stage),
        .rdata (rdata),
        .wb    (wb)
    );

endmodule

`default_nettype wire

//--- bench/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// byte shadow of the data RAM, index is the byte address inside the RAM
logic [7:0] shadow [RAM_WORDS*4];

// {adel, ades} for one request
function automatic logic [1:0] ref_align(input mem_req_t r);
    logic half_bad;
    logic word_bad;
    half_bad = r.ls_addr[0];
    word_bad = |r.ls_addr[1:0];
    if (!r.ls_ena) begin
        return 2'b00;
    end
    case (r.ls_sel)
        LS_LH, LS_LHU: return {half_bad, 1'b0};
        LS_LW:         return {word_bad, 1'b0};
        LS_SH:         return {1'b0, half_bad};
        LS_SW:         return {1'b0, word_bad};
        default:       return 2'b00;
    endcase
endfunction

// which byte of rt lands in a RAM lane, -1 when the lane is not written
function automatic int store_src(input ls_sel_e sel, input int lo, input int lane);
    case (sel)
        LS_SB:   return (lane == lo) ? 0 : -1;
        LS_SH:   return (lane / 2 == lo / 2) ? lane % 2 : -1;
        LS_SW:   return lane;
        LS_SWL:  return (lane <= lo) ? 3 - lo + lane : -1;
        LS_SWR:  return (lane >= lo) ? lane - lo : -1;
        default: return -1;
    endcase
endfunction

function automatic logic [3:0] ref_byte_en(input ls_sel_e sel, input int lo);
    logic [3:0] en;
    int i;
    en = 4'b0000;
    for (i = 0; i < 4; i++) begin
        en[i] = (store_src(sel, lo, i) >= 0);
    end
    return en;
endfunction

function automatic logic [31:0] ref_store_data(input ls_sel_e sel, input int lo,
                                               input logic [31:0] rt);
    logic [31:0] d;
    int i;
    int src;
    d = 32'h0;
    for (i = 0; i < 4; i++) begin
        src = store_src(sel, lo, i);
        if (src >= 0) begin
            d[8*i +: 8] = rt[8*src +: 8];
        end
    end
    return d;
endfunction

// loaded value, with rt as the merge source for LWL and LWR
function automatic logic [31:0] ref_load(input ls_sel_e sel, input int lo,
                                         input logic [31:0] word, input logic [31:0] rt);
    logic [7:0]  b;
    logic [15:0] h;
    logic [31:0] res;
    int i;
    b   = word[8*lo +: 8];
    h   = word[16*(lo/2) +: 16];
    res = rt;
    case (sel)
        LS_LB:  res = {{24{b[7]}}, b};
        LS_LBU: res = {24'h0, b};
        LS_LH:  res = {{16{h[15]}}, h};
        LS_LHU: res = {16'h0, h};
        LS_LW:  res = word;
        LS_LWL: begin
            for (i = 0; i <= lo; i++) begin
                res[8*(3-lo+i) +: 8] = word[8*i +: 8];
            end
        end
        LS_LWR: begin
            for (i = lo; i < 4; i++) begin
                res[8*(i-lo) +: 8] = word[8*i +: 8];
            end
        end
        default: res = 32'h0;
    endcase
    return res;
endfunction

function automatic logic [31:0] shadow_word(input logic [31:0] addr);
    int base;
    base = int'(addr[RAM_AW+1:2]) * 4;
    return {shadow[base+3], shadow[base+2], shadow[base+1], shadow[base]};
endfunction

task automatic shadow_store(input logic [31:0] addr, input logic [3:0] en,
                            input logic [31:0] data);
    int base;
    int i;
    base = int'(addr[RAM_AW+1:2]) * 4;
    for (i = 0; i < 4; i++) begin
        if (en[i]) begin
            shadow[base+i] = data[8*i +: 8];
        end
    end
endtask

`endif

//--- bench/tb_mem_stage.sv
`default_nettype none

module tb_mem_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import lsu_pkg::*;

    `include "tb_ref.svh"

    localparam int RESET_CYCLES = 10;
    localparam int RAND_PAIRS   = 100;
    localparam int MIX_CYCLES   = 400;
    localparam int N_REQ        = 2*RAM_WORDS + 2*RAND_PAIRS + 5*3 + 6 + MIX_CYCLES + 4;
    localparam int TIMEOUT_NS   = (N_REQ + RESET_CYCLES) * 10 * 2;

    logic     clk;
    logic     reset;
    mem_req_t req;
    wb_t      wb;
    logic     adel;
    logic     ades;

    integer seed;
    int     errors = 0;
    string  test_name;

    // model state for the request in flight
    wb_t         exp_wb = '0;
    string       exp_name = "reset state";
    logic [31:0] last_rdata = 32'h0;
    logic        prev_exc = 1'b0;

    ls_sel_e    store_ops [4] = '{LS_SB, LS_SH, LS_SWL, LS_SWR};
    ls_sel_e    load_ops [6]  = '{LS_LB, LS_LBU, LS_LH, LS_LHU, LS_LWL, LS_LWR};
    ls_sel_e    bad_sel [5]   = '{LS_LH, LS_LHU, LS_LW, LS_SH, LS_SW};
    logic [1:0] bad_lo [5]    = '{2'd1, 2'd3, 2'd2, 2'd1, 2'd3};

    mem_stage u_dut (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .wb    (wb),
        .adel  (adel),
        .ades  (ades)
    );

    always #5 clk = ~clk;

    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("TB FAILED");
            $fatal(1, "write-back mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            $display("TB FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    // expected write-back one cycle after the request
    function automatic wb_t expect_wb(input mem_req_t r, input logic [31:0] word,
                                      input logic exc);
        wb_t w;
        w.valid         = r.ls_ena | r.w_reg_ena;
        w.w_reg_ena     = r.w_reg_ena & ~exc;
        w.w_reg_dst     = r.w_reg_dst;
        w.r_data        = r.ls_ena ? ref_load(r.ls_sel, int'(r.ls_addr[1:0]), word,
                                              r.rt_data) : 32'h0;
        w.has_exception = exc;
        return w;
    endfunction

    function automatic mem_req_t make_req(input ls_sel_e sel, input logic [31:0] addr,
                                          input logic ex_exc);
        mem_req_t r;
        r.ls_ena    = (sel != LS_NONE);
        r.ls_sel    = sel;
        r.ls_addr   = addr;
        r.rt_data   = $random(seed);
        r.w_reg_ena = (sel >= LS_LB) && (sel <= LS_LWR);
        r.w_reg_dst = 5'($random(seed));
        r.ex_exc    = ex_exc;
        return r;
    endfunction

    // random offset inside the word of base, halfword ops kept aligned
    function automatic logic [31:0] rand_addr(input ls_sel_e sel, input logic [31:0] base);
        logic [1:0] lo;
        lo = 2'($random(seed));
        if (sel == LS_SH || sel == LS_LH || sel == LS_LHU) begin
            lo[0] = 1'b0;
        end
        return {base[31:2], lo};
    endfunction

    task automatic drive(input string name, input mem_req_t r);
        @(posedge clk);
        req <= r;
        test_name = name;
    endtask

    // inputs settle after the rising edge, so compare on the falling one
    always @(negedge clk) begin
        logic [1:0] err;
        logic       exc;
        int         lo;
        if (!reset) begin
            check_wb(exp_name, exp_wb, wb);
            err = ref_align(req);
            check_flag({test_name, " adel"}, err[1], adel);
            check_flag({test_name, " ades"}, err[0], ades);
            exc = req.ex_exc | err[1] | err[0];
            lo  = int'(req.ls_addr[1:0]);
            // read sees the old word, write lands at the same edge
            if (req.ls_ena && !exc && !prev_exc) begin
                last_rdata = shadow_word(req.ls_addr);
                shadow_store(req.ls_addr, ref_byte_en(req.ls_sel, lo),
                             ref_store_data(req.ls_sel, lo, req.rt_data));
            end
            exp_wb   = expect_wb(req, last_rdata, exc);
            exp_name = test_name;
            prev_exc = exc;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int          w;
        int          k;
        mem_req_t    r;
        logic [31:0] base;
        ls_sel_e     sel;
        seed      = 32'h6adf;
        clk       = 1'b0;
        reset     = 1'b1;
        req       = '0;
        test_name = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        @(negedge clk);
        check_flag("reset wb.valid", 1'b0, wb.valid);
        check_flag("reset adel", 1'b0, adel);
        check_flag("reset ades", 1'b0, ades);

        for (w = 0; w < RAM_WORDS; w++) begin
            drive("word store", make_req(LS_SW, 32'(w) << 2, 1'b0));
        end
        for (w = 0; w < RAM_WORDS; w++) begin
            drive("word load", make_req(LS_LW, 32'(w) << 2, 1'b0));
        end

        for (k = 0; k < RAND_PAIRS; k++) begin
            base = $random(seed);
            sel  = store_ops[$unsigned($random(seed)) % 4];
            drive("subword store", make_req(sel, rand_addr(sel, base), 1'b0));
            sel  = load_ops[$unsigned($random(seed)) % 6];
            drive("subword load", make_req(sel, rand_addr(sel, base), 1'b0));
        end

        // idle slot keeps the reload out of the shadow of the error
        for (k = 0; k < 5; k++) begin
            base = $random(seed);
            drive("misaligned access", make_req(bad_sel[k], {base[31:2], bad_lo[k]}, 1'b0));
            @(negedge clk);
            check_flag("misaligned error flag", 1'b1, adel | ades);
            drive("idle after error", make_req(LS_NONE, 32'h0, 1'b0));
            drive("reload after error", make_req(LS_LW, {base[31:2], 2'b00}, 1'b0));
        end

        base = $random(seed);
        drive("store with ex_exc", make_req(LS_SW, {base[31:2], 2'b00}, 1'b1));
        drive("store after exception", make_req(LS_SB, {base[31:2] + 30'd1, 2'b01}, 1'b0));
        drive("store with ex_exc", make_req(LS_SW, {base[31:2], 2'b00}, 1'b1));
        drive("load after exception", make_req(LS_LW, {base[31:2], 2'b00}, 1'b0));
        drive("reload suppressed word", make_req(LS_LW, {base[31:2], 2'b00}, 1'b0));
        drive("reload suppressed byte", make_req(LS_LW, {base[31:2] + 30'd1, 2'b00}, 1'b0));

        for (k = 0; k < MIX_CYCLES; k++) begin
            sel      = ls_sel_e'(4'($unsigned($random(seed)) % 13));
            r        = make_req(sel, $random(seed), ($random(seed) & 15) == 0);
            r.ls_ena = r.ls_ena & (($random(seed) & 7) != 0);
            if (!r.ls_ena) begin
                r.w_reg_ena = 1'($random(seed));
            end
            drive("mixed traffic", r);
        end

        drive("idle", make_req(LS_NONE, 32'h0, 1'b0));
        drive("idle", make_req(LS_NONE, 32'h0, 1'b0));
        @(negedge clk);
        if (errors == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("TB FAILED");
            $fatal(1, "%0d checks failed", errors);
        end
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+bench
verilog/lsu_pkg.sv
verilog/store_format.sv
verilog/data_ram.sv
verilog/ex_mem_reg.sv
verilog/load_align.sv
verilog/mem_stage.sv
bench/tb_mem_stage.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_mem_stage -o sim_mem_stage \
    && ./obj_dir/sim_mem_stage | tee /dev/stderr | grep -q "TB PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
